/* design/videoPkg.sv */
`default_nettype none

package videoPkg;

  // one pixel, red in the top byte.
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgbT;

  // small raster so a frame simulates quickly.
  localparam int HActive = 16;
  localparam int HFront  = 2;
  localparam int HSync   = 4;
  localparam int HBack   = 4;
  localparam int HTotal  = HActive + HFront + HSync + HBack;  // 26.

  localparam int VActive = 4;
  localparam int VFront  = 1;
  localparam int VSync   = 2;
  localparam int VBack   = 1;
  localparam int VTotal  = VActive + VFront + VSync + VBack;  // 8.

  localparam int PixPerFrame = HActive * VActive;
  localparam int FifoDepth   = 32;

endpackage

`default_nettype wire

/* design/tmdsPkg.sv */
`default_nettype none

package tmdsPkg;

  // one 10-bit character, bit 0 goes out first.
  typedef logic [9:0] symbolT;

  // ones minus zeros sent so far, always even.
  typedef logic signed [4:0] disparityT;

  // control characters, named by {c1, c0}.
  localparam symbolT CtrlCode00 = 10'b1101010100;
  localparam symbolT CtrlCode01 = 10'b0010101011;
  localparam symbolT CtrlCode10 = 10'b0101010100;
  localparam symbolT CtrlCode11 = 10'b1010101011;

endpackage

`default_nettype wire

/* design/pixelSource.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelSource
(
  input  logic          PixClk,
  input  logic          rstN,
  input  logic          sourceRun,
  input  logic          pixReady,
  output videoPkg::rgbT pixData,
  output logic          pixValid
);
  import videoPkg::*;

  localparam int IdxW = $clog2(PixPerFrame);

  logic [IdxW-1:0] pixIdx;   // n, pixel within the frame.
  logic [7:0]      frameCnt; // f mod 256.
  logic            xfer;

  assign xfer = pixValid && pixReady;

  // pattern is a pure function of n and f, so it only moves on a transfer.
  assign pixData = '{
    red:   {pixIdx, 2'b00},
    green: frameCnt,
    blue:  ~{pixIdx, 2'b00}
  };

  always_ff @(posedge PixClk or negedge rstN)
  begin
    if (!rstN)
    begin
      pixIdx   <= '0;
      frameCnt <= '0;
      pixValid <= 1'b0;
    end
    else
    begin
      if (xfer)
      begin
        if (pixIdx == IdxW'(PixPerFrame - 1))
        begin
          pixIdx   <= '0;
          frameCnt <= frameCnt + 8'd1;
        end
        else
        begin
          pixIdx <= pixIdx + 1'b1;
        end
      end
      // an offer already made stays up until it is taken.
      if (!pixValid || xfer)
        pixValid <= sourceRun;
    end
  end

  // a stalled offer keeps both its valid and its data.
  assert property (@(posedge PixClk) disable iff (!rstN)
    pixValid && !pixReady |=> pixValid && $stable(pixData));

endmodule

`default_nettype wire

/* design/pixelFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelFifo
#(
  parameter int Depth = videoPkg::FifoDepth
)
(
  input  logic          PixClk,
  input  logic          rstN,
  input  videoPkg::rgbT wrData,
  input  logic          wrValid,
  output logic          wrReady,
  output logic          rdValid,
  input  logic          rdReady,
  output videoPkg::rgbT rdData
);
  import videoPkg::*;

  localparam int AddrW = $clog2(Depth);

  rgbT            mem [Depth];
  logic [AddrW:0] wrPtr;  // extra bit tells full from empty.
  logic [AddrW:0] rdPtr;
  logic           full;
  logic           empty;
  logic           doWrite;
  logic           doRead;

  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[AddrW] != rdPtr[AddrW]) &&
                 (wrPtr[AddrW-1:0] == rdPtr[AddrW-1:0]);

  assign wrReady = !full;
  assign rdValid = !empty;
  assign rdData  = mem[rdPtr[AddrW-1:0]];  // head falls through.

  assign doWrite = wrValid && wrReady;
  assign doRead  = rdReady && rdValid;

  always_ff @(posedge PixClk)
  begin
    if (doWrite)
      mem[wrPtr[AddrW-1:0]] <= wrData;
  end

  always_ff @(posedge PixClk or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= wrPtr + 1'b1;
      if (doRead)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  // occupancy never runs past full or below empty.
  assert property (@(posedge PixClk) disable iff (!rstN)
    (AddrW+1)'(wrPtr - rdPtr) <= (AddrW+1)'(Depth));

endmodule

`default_nettype wire

/* design/tmdsChannelEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tmdsChannelEncoder
(
  input  logic            PixClk,
  input  logic            rstN,
  input  logic [7:0]      data,
  input  logic            c0,
  input  logic            c1,
  input  logic            de,
  output tmdsPkg::symbolT symbol
);
  import tmdsPkg::*;

  logic [3:0] n1Data;
  logic       useXnor;
  logic [8:0] qm;        // transition minimised word.
  logic [3:0] n1Qm;
  disparityT  qmBal;     // ones minus zeros in qm[7:0].
  disparityT  disparity;
  disparityT  dispNext;
  logic       invert;
  symbolT     symNext;

  // stage one, pick the xor or xnor chain.
  always_comb
  begin
    n1Data  = 4'($countones(data));
    useXnor = (n1Data > 4'd4) || ((n1Data == 4'd4) && !data[0]);
    qm[0]   = data[0];
    for (int i = 1; i < 8; i++)
    begin
      qm[i] = useXnor ? ~(qm[i-1] ^ data[i]) : (qm[i-1] ^ data[i]);
    end
    qm[8] = !useXnor;
  end

  // stage two, dc balance against the running disparity.
  always_comb
  begin
    n1Qm  = 4'($countones(qm[7:0]));
    qmBal = ($signed({1'b0, n1Qm}) - 5'sd4) <<< 1;
    if ((disparity == 5'sd0) || (n1Qm == 4'd4))
    begin
      invert   = !qm[8];
      dispNext = qm[8] ? disparity + qmBal : disparity - qmBal;
    end
    else if (((disparity > 5'sd0) && (n1Qm > 4'd4)) ||
             ((disparity < 5'sd0) && (n1Qm < 4'd4)))
    begin
      invert   = 1'b1;
      dispNext = disparity - qmBal + (qm[8] ? 5'sd2 : 5'sd0);
    end
    else
    begin
      invert   = 1'b0;
      dispNext = disparity + qmBal - (qm[8] ? 5'sd0 : 5'sd2);
    end
    symNext = {invert, qm[8], invert ? ~qm[7:0] : qm[7:0]};

    if (!de)
    begin
      dispNext = '0;  // control periods restart the balance.
      case ({c1, c0})
        2'b01:   symNext = CtrlCode01;
        2'b10:   symNext = CtrlCode10;
        2'b11:   symNext = CtrlCode11;
        default: symNext = CtrlCode00;
      endcase
    end
  end

  always_ff @(posedge PixClk or negedge rstN)
  begin
    if (!rstN)
    begin
      symbol    <= CtrlCode00;
      disparity <= '0;
    end
    else
    begin
      symbol    <= symNext;
      disparity <= dispNext;
    end
  end

  // the balance rule keeps the line within one byte's worth of skew.
  assert property (@(posedge PixClk) disable iff (!rstN)
    !disparity[0] && (disparity >= -5'sd8) && (disparity <= 5'sd8));

endmodule

`default_nettype wire

/* design/dviScanout.sv */
`timescale 1ns/1ps
`default_nettype none

module dviScanout
(
  input  logic            PixClk,
  input  logic            rstN,
  input  videoPkg::rgbT   fifoData,
  input  logic            fifoValid,
  output logic            fifoReady,
  output tmdsPkg::symbolT tmdsBlue,
  output tmdsPkg::symbolT tmdsGreen,
  output tmdsPkg::symbolT tmdsRed,
  output logic            underflow
);
  import videoPkg::*;

  localparam int HCntW = $clog2(HTotal);
  localparam int VCntW = $clog2(VTotal);

  localparam logic [HCntW-1:0] HLast      = HCntW'(HTotal - 1);
  localparam logic [HCntW-1:0] HActEnd    = HCntW'(HActive);
  localparam logic [HCntW-1:0] HSyncStart = HCntW'(HActive + HFront);
  localparam logic [HCntW-1:0] HSyncEnd   = HCntW'(HActive + HFront + HSync);
  localparam logic [VCntW-1:0] VLast      = VCntW'(VTotal - 1);
  localparam logic [VCntW-1:0] VActEnd    = VCntW'(VActive);
  localparam logic [VCntW-1:0] VSyncStart = VCntW'(VActive + VFront);
  localparam logic [VCntW-1:0] VSyncEnd   = VCntW'(VActive + VFront + VSync);

  logic [HCntW-1:0] hCount;
  logic [VCntW-1:0] vCount;
  logic             active;
  logic             hsync;
  logic             vsync;
  logic             deQ;
  logic             hsyncQ;
  logic             vsyncQ;
  rgbT              pixQ;

  // free running raster that never waits on the fifo.
  always_ff @(posedge PixClk or negedge rstN)
  begin
    if (!rstN)
    begin
      hCount <= '0;
      vCount <= VLast;  // start in the back porch so the fifo fills first.
    end
    else if (hCount == HLast)
    begin
      hCount <= '0;
      vCount <= (vCount == VLast) ? '0 : vCount + 1'b1;
    end
    else
    begin
      hCount <= hCount + 1'b1;
    end
  end

  assign active = (hCount < HActEnd) && (vCount < VActEnd);
  assign hsync  = (hCount >= HSyncStart) && (hCount < HSyncEnd);
  assign vsync  = (vCount >= VSyncStart) && (vCount < VSyncEnd);

  assign fifoReady = active;  // pop one pixel per active slot.

  always_ff @(posedge PixClk or negedge rstN)
  begin
    if (!rstN)
    begin
      deQ       <= 1'b0;
      hsyncQ    <= 1'b0;
      vsyncQ    <= 1'b0;
      underflow <= 1'b0;
    end
    else
    begin
      deQ    <= active;
      hsyncQ <= hsync;
      vsyncQ <= vsync;
      if (active && !fifoValid)
        underflow <= 1'b1;  // sticky until reset.
    end
  end

  always_ff @(posedge PixClk)
  begin
    pixQ <= fifoValid ? fifoData : '0;  // black when starved.
  end

  tmdsChannelEncoder blueEnc
  (
    .PixClk (PixClk),
    .rstN   (rstN),
    .data   (pixQ.blue),
    .c0     (hsyncQ),
    .c1     (vsyncQ),
    .de     (deQ),
    .symbol (tmdsBlue)
  );

  tmdsChannelEncoder greenEnc
  (
    .PixClk (PixClk),
    .rstN   (rstN),
    .data   (pixQ.green),
    .c0     (1'b0),
    .c1     (1'b0),
    .de     (deQ),
    .symbol (tmdsGreen)
  );

  tmdsChannelEncoder redEnc
  (
    .PixClk (PixClk),
    .rstN   (rstN),
    .data   (pixQ.red),
    .c0     (1'b0),
    .c1     (1'b0),
    .de     (deQ),
    .symbol (tmdsRed)
  );

  // syncs only ever travel in blanking.
  assert property (@(posedge PixClk) disable iff (!rstN)
    deQ |-> !hsyncQ && !vsyncQ);

endmodule

`default_nettype wire

/* design/dviTransmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module dviTransmitter
(
  input  logic            PixClk,
  input  logic            rstN,
  input  logic            sourceRun,
  output tmdsPkg::symbolT tmdsBlue,
  output tmdsPkg::symbolT tmdsGreen,
  output tmdsPkg::symbolT tmdsRed,
  output logic            underflow
);
  import videoPkg::*;

  rgbT  pixData;
  logic pixValid;
  logic pixReady;
  rgbT  fifoData;
  logic fifoValid;
  logic fifoReady;

  pixelSource source
  (
    .PixClk    (PixClk),
    .rstN      (rstN),
    .sourceRun (sourceRun),
    .pixReady  (pixReady),
    .pixData   (pixData),
    .pixValid  (pixValid)
  );

  pixelFifo #(.Depth(FifoDepth)) fifo
  (
    .PixClk  (PixClk),
    .rstN    (rstN),
    .wrData  (pixData),
    .wrValid (pixValid),
    .wrReady (pixReady),
    .rdValid (fifoValid),
    .rdReady (fifoReady),
    .rdData  (fifoData)
  );

  dviScanout scanout
  (
    .PixClk    (PixClk),
    .rstN      (rstN),
    .fifoData  (fifoData),
    .fifoValid (fifoValid),
    .fifoReady (fifoReady),
    .tmdsBlue  (tmdsBlue),
    .tmdsGreen (tmdsGreen),
    .tmdsRed   (tmdsRed),
    .underflow (underflow)
  );

endmodule

`default_nettype wire

/* tb/tmdsCheck.svh */
`ifndef TMDS_CHECK_SVH
`define TMDS_CHECK_SVH

// bit changes between neighbours, nine pairs per symbol.
function automatic int transitions(input tmdsPkg::symbolT s);
  int cnt;
  cnt = 0;
  for (int i = 1; i < 10; i++)
  begin
    if (s[i] != s[i-1])
      cnt++;
  end
  return cnt;
endfunction

// control codes are the only legal symbols this busy.
function automatic bit isCtrlSym(input tmdsPkg::symbolT s);
  return transitions(s) >= 7;
endfunction

function automatic bit isCtrlCode(input tmdsPkg::symbolT s);
  return (s == tmdsPkg::CtrlCode00) || (s == tmdsPkg::CtrlCode01) ||
         (s == tmdsPkg::CtrlCode10) || (s == tmdsPkg::CtrlCode11);
endfunction

// returns {c1, c0}.
function automatic logic [1:0] ctrlBits(input tmdsPkg::symbolT s);
  case (s)
    tmdsPkg::CtrlCode01: return 2'b01;
    tmdsPkg::CtrlCode10: return 2'b10;
    tmdsPkg::CtrlCode11: return 2'b11;
    default:             return 2'b00;
  endcase
endfunction

function automatic logic [8:0] decodeQm(input tmdsPkg::symbolT s);
  return {s[8], s[9] ? ~s[7:0] : s[7:0]};
endfunction

function automatic logic [7:0] decodeData(input tmdsPkg::symbolT s);
  logic [8:0] qm;
  logic [7:0] d;
  qm   = decodeQm(s);
  d[0] = qm[0];
  for (int i = 1; i < 8; i++)
  begin
    d[i] = qm[8] ? (qm[i] ^ qm[i-1]) : ~(qm[i] ^ qm[i-1]);  // bit 8 set means xor.
  end
  return d;
endfunction

// ones minus zeros on the wire.
function automatic int symBalance(input tmdsPkg::symbolT s);
  return 2 * int'($countones(s)) - 10;
endfunction

function automatic bit wantInvert(input int disp, input logic [8:0] qm);
  int n1;
  n1 = int'($countones(qm[7:0]));
  if ((disp == 0) || (n1 == 4))
    return !qm[8];
  if (((disp > 0) && (n1 > 4)) || ((disp < 0) && (n1 < 4)))
    return 1'b1;
  return 1'b0;
endfunction

function automatic videoPkg::rgbT patternPixel(input int n, input int f);
  videoPkg::rgbT p;
  p.red   = 8'(4 * n);
  p.green = 8'(f);
  p.blue  = ~8'(4 * n);
  return p;
endfunction

`endif

/* tb/dviTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dviTb;
  import videoPkg::*;
  import tmdsPkg::*;

  `include "tmdsCheck.svh"

  localparam int FrameCycles = HTotal * VTotal;
  localparam int FramesRun   = 7;      // startup, three paused, one starved, two recovery.
  localparam realtime WatchdogNs = (FramesRun + 2) * FrameCycles * 20.0;

  logic   PixClk;
  logic   rstN;
  logic   sourceRun;
  symbolT tmdsBlue;
  symbolT tmdsGreen;
  symbolT tmdsRed;
  logic   underflow;

  int     seed;
  int     patErr, balErr, rasErr, otherErr;
  int     disp [3];
  int     expN, expF, blackSlots, pixChecked, framesSeen;
  int     cyc, dataRun, hsRun, vsRun, lines;
  int     dataEndCyc, hsFallCyc, vsFallCyc, lastHsRise;
  bit     dataSeen, underflowSeen, prevData, prevHs, prevVs;
  bit     isDataB, isDataG, isDataR, hs, vs;
  logic [1:0] cb;
  rgbT    got, want;

  dviTransmitter DUT
  (
    .PixClk    (PixClk),
    .rstN      (rstN),
    .sourceRun (sourceRun),
    .tmdsBlue  (tmdsBlue),
    .tmdsGreen (tmdsGreen),
    .tmdsRed   (tmdsRed),
    .underflow (underflow)
  );

  initial
  begin
    PixClk = 1'b0;
    forever #10 PixClk = ~PixClk;
  end

  initial
  begin
    #(WatchdogNs);
    $display("timeout, the run did not finish within %0t", $realtime);
    $display("Some tests failed");
    $finish;
  end

  // tracks its own disparity from the wire and checks the invert bit.
  task automatic checkBalance(input int ch, input symbolT sym, input string name);
    logic [8:0] qm;
    bit         inv;
    if (isCtrlSym(sym))
    begin
      disp[ch] = 0;
    end
    else
    begin
      qm  = decodeQm(sym);
      inv = wantInvert(disp[ch], qm);
      assert (sym[9] == inv) else
      begin
        balErr++;
        $display("[FAIL] %s bit9 got %h expected %h", name, sym[9], inv);
      end
      disp[ch] += symBalance(sym);
      assert ((disp[ch] >= -8) && (disp[ch] <= 8)) else
      begin
        balErr++;
        $display("[FAIL] %s disparity %h out of range", name, disp[ch]);
      end
    end
  endtask

  task automatic runPauses(input int cycles);
    int left;
    int runLen;
    int pauseLen;
    left = cycles;
    while (left > 0)
    begin
      runLen   = 20 + ({$random(seed)} % 16);
      pauseLen = 1 + ({$random(seed)} % 8);  // well under the fifo slack.
      sourceRun = 1'b1;
      repeat (runLen) @(negedge PixClk);
      sourceRun = 1'b0;
      repeat (pauseLen) @(negedge PixClk);
      left -= runLen + pauseLen;
    end
    sourceRun = 1'b1;
  endtask

  always @(negedge PixClk)
  begin
    if (!rstN)
    begin
      assert (tmdsRed == CtrlCode00 && tmdsGreen == CtrlCode00 && tmdsBlue == CtrlCode00 &&
              !underflow) else
      begin
        otherErr++;
        $display("outputs not in their reset state while reset is held");
      end
    end
    else
    begin
      cyc++;
      isDataB = !isCtrlSym(tmdsBlue);
      isDataG = !isCtrlSym(tmdsGreen);
      isDataR = !isCtrlSym(tmdsRed);
      assert (isDataR == isDataB && isDataG == isDataB) else
      begin
        rasErr++;
        $display("channels disagree on data versus control at cycle %0d", cyc);
      end
      if (!isDataR)
        assert (tmdsRed == CtrlCode00) else
        begin
          rasErr++;
          $display("[FAIL] tmdsRed got %h expected %h", tmdsRed, CtrlCode00);
        end
      if (!isDataG)
        assert (tmdsGreen == CtrlCode00) else
        begin
          rasErr++;
          $display("[FAIL] tmdsGreen got %h expected %h", tmdsGreen, CtrlCode00);
        end
      if (!isDataB)
        assert (isCtrlCode(tmdsBlue)) else
        begin
          rasErr++;
          $display("[FAIL] tmdsBlue illegal control symbol %h", tmdsBlue);
        end
      if (!dataSeen)
        assert (!underflow) else
        begin
          otherErr++;
          $display("underflow raised before the first active line");
        end
      if (underflow)
        underflowSeen = 1'b1;
      if (underflowSeen)
        assert (underflow) else
        begin
          otherErr++;
          $display("underflow dropped without a reset");
        end
      checkBalance(0, tmdsBlue, "tmdsBlue");
      checkBalance(1, tmdsGreen, "tmdsGreen");
      checkBalance(2, tmdsRed, "tmdsRed");

      // pixels must arrive in order with black slots counted only as gaps.
      if (isDataB)
      begin
        dataSeen = 1'b1;
        got = {decodeData(tmdsRed), decodeData(tmdsGreen), decodeData(tmdsBlue)};
        if (got == '0)
        begin
          blackSlots++;
          assert (underflow) else
          begin
            otherErr++;
            $display("black slot sent without the underflow flag");
          end
        end
        else
        begin
          want = patternPixel(expN, expF);
          assert (got == want) else
          begin
            patErr++;
            $display("[FAIL] pixel got %h expected %h", got, want);
          end
          pixChecked++;
          expN++;
          if (expN == PixPerFrame)
          begin
            expN = 0;
            expF++;
          end
        end
      end

      cb = isDataB ? 2'b00 : ctrlBits(tmdsBlue);
      hs = cb[0];
      vs = cb[1];
      if (isDataB && !prevData)
      begin
        if (hsFallCyc > 0)
          assert (cyc - hsFallCyc == HBack) else
          begin
            rasErr++;
            $display("[FAIL] hback got %h expected %h", cyc - hsFallCyc, HBack);
          end
        if (lines == 0 && vsFallCyc > 0)
          assert (cyc - vsFallCyc == VBack * HTotal) else
          begin
            rasErr++;
            $display("[FAIL] vback got %h expected %h", cyc - vsFallCyc, VBack * HTotal);
          end
        dataRun = 0;
      end
      if (isDataB)
        dataRun++;
      if (!isDataB && prevData)
      begin
        assert (dataRun == HActive) else
        begin
          rasErr++;
          $display("[FAIL] line length got %h expected %h", dataRun, HActive);
        end
        lines++;
        dataEndCyc = cyc;
      end
      if (hs && !prevHs)
      begin
        if (lastHsRise > 0)
          assert (cyc - lastHsRise == HTotal) else
          begin
            rasErr++;
            $display("[FAIL] hsync period got %h expected %h", cyc - lastHsRise, HTotal);
          end
        if (cyc - dataEndCyc < HTotal)
          assert (cyc - dataEndCyc == HFront) else
          begin
            rasErr++;
            $display("[FAIL] hfront got %h expected %h", cyc - dataEndCyc, HFront);
          end
        lastHsRise = cyc;
        hsRun = 0;
      end
      if (hs)
        hsRun++;
      if (!hs && prevHs)
      begin
        assert (hsRun == HSync) else
        begin
          rasErr++;
          $display("[FAIL] hsync width got %h expected %h", hsRun, HSync);
        end
        hsFallCyc = cyc;
      end
      if (vs && !prevVs)
      begin
        assert (lines == VActive) else
        begin
          rasErr++;
          $display("[FAIL] active lines got %h expected %h", lines, VActive);
        end
        assert (cyc - dataEndCyc == HTotal - HActive + VFront * HTotal) else
        begin
          rasErr++;
          $display("[FAIL] vfront got %h expected %h", cyc - dataEndCyc,
                   HTotal - HActive + VFront * HTotal);
        end
        lines = 0;
        framesSeen++;
        vsRun = 0;
      end
      if (vs)
        vsRun++;
      if (!vs && prevVs)
      begin
        assert (vsRun == VSync * HTotal) else
        begin
          rasErr++;
          $display("[FAIL] vsync width got %h expected %h", vsRun, VSync * HTotal);
        end
        vsFallCyc = cyc;
      end
      prevData = isDataB;
      prevHs   = hs;
      prevVs   = vs;
    end
  end

  initial
  begin
    int total;
    rstN       = 1'b0;
    sourceRun  = 1'b1;
    seed       = 32'h8959;
    dataEndCyc = -10000;
    hsFallCyc  = -1;
    vsFallCyc  = -1;
    lastHsRise = -1;
    repeat (5) @(negedge PixClk);
    rstN = 1'b1;
    repeat (FrameCycles) @(negedge PixClk);
    runPauses(3 * FrameCycles);
    assert (!underflow && blackSlots == 0) else
    begin
      otherErr++;
      $display("fifo ran dry during source pauses, %0d black slots", blackSlots);
    end
    sourceRun = 1'b0;  // starve the raster for a whole frame.
    repeat (FrameCycles) @(negedge PixClk);
    sourceRun = 1'b1;
    repeat (2 * FrameCycles) @(negedge PixClk);
    assert (underflow && blackSlots > 0) else
    begin
      otherErr++;
      $display("starving the fifo did not show as underflow");
    end
    assert (framesSeen >= FramesRun - 1 && pixChecked > 0) else
    begin
      otherErr++;
      $display("too few frames or pixels were observed");
    end
    total = patErr + balErr + rasErr + otherErr;
    $display("errors %0d (pattern %0d, balance %0d, raster %0d, other %0d), pixels %0d",
             total, patErr, balErr, rasErr, otherErr, pixChecked);
    if (total == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dviTx.f */
+incdir+tb
design/videoPkg.sv
design/tmdsPkg.sv
design/pixelSource.sv
design/pixelFifo.sv
design/tmdsChannelEncoder.sv
design/dviScanout.sv
design/dviTransmitter.sv
tb/dviTb.sv

/* runSim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f dviTx.f --top-module dviTb -o dviSim

./obj_dir/dviSim | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
